/* pcie_rx_data_handler.f */
hw/pcie_symbol_pkg.sv
hw/rx_stream_pkg.sv
hw/rx_axis_if.sv
hw/frame_symbol_scan.sv
hw/rx_framer.sv
hw/axis_skid_buffer.sv
hw/pcie_rx_data_handler.sv
test/tb_clock_gen.sv
test/tb_pcie_rx_data_handler.sv

/* test/tb_pcie_rx_data_handler.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_pcie_rx_data_handler;

  // 8b/10b framing codes
  localparam logic [7:0] SYM_STP  = 8'hFB;
  localparam logic [7:0] SYM_SDP  = 8'h5C;
  localparam logic [7:0] SYM_END  = 8'hFD;
  localparam logic [7:0] SYM_EDB  = 8'hFE;
  localparam logic [7:0] SYM_IDLE = 8'h00;
  // link goes up late and drops once mid traffic
  localparam int LINK_UP_CYCLE = 20;
  localparam int DROP_FIRST    = 50;
  localparam int DROP_LAST     = 70;
  localparam int SETTLE_CYCLES = 20;

  logic        clk;
  logic        rst;
  logic        phy_link_up;
  logic [31:0] data;
  logic [3:0]  data_k;
  logic        data_valid;
  logic        fifo_rd_en;
  logic [31:0] tdata;
  logic [3:0]  tkeep;
  logic        tvalid;
  logic        tlast;
  logic        tuser;
  logic        tready;

  // packet table
  string row_name[$];
  bit    row_tlp[$];
  int    row_len[$];
  int    row_fill[$];
  bit    row_edb[$];
  // symbol stream and fifo words
  logic [7:0]  sym_q[$];
  bit          symk_q[$];
  logic [31:0] fifo_data_q[$];
  logic [3:0]  fifo_k_q[$];
  // expected beats in order
  logic [31:0] exp_data_q[$];
  logic [3:0]  exp_keep_q[$];
  bit          exp_last_q[$];
  bit          exp_user_q[$];
  int          exp_row_q[$];

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_tb_clock_gen (
    .clk_o(clk),
    .rst_o(rst)
  );

  pcie_rx_data_handler #(.DATA_WIDTH(32)) u_pcie_rx_data_handler (
    .clk_i           (clk),
    .rst_i           (rst),
    .phy_link_up_i   (phy_link_up),
    .data_i          (data),
    .data_k_i        (data_k),
    .data_valid_i    (data_valid),
    .phy_fifo_rd_en_o(fifo_rd_en),
    .m_axis_tdata_o  (tdata),
    .m_axis_tkeep_o  (tkeep),
    .m_axis_tvalid_o (tvalid),
    .m_axis_tlast_o  (tlast),
    .m_axis_tuser_o  (tuser),
    .m_axis_tready_i (tready)
  );

  // payload pattern from row and byte position
  function automatic logic [7:0] payload_byte(int row, int pos);
    return 8'(row * 37 + pos * 11 + 3);
  endfunction

  function automatic logic [31:0] keep_mask(logic [3:0] keep);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{keep[i]}};
    end
    return m;
  endfunction

  // stall phases picked by beat count
  function automatic bit pick_ready(int idx);
    if (idx < 6) return 1'b1;
    if (idx < 16) return 1'($urandom % 2);
    if (idx < 24) return (($urandom % 4) == 0);
    return 1'b1;
  endfunction

  task automatic add_row(string name, bit tlp, int len, int fill, bit edb);
    row_name.push_back(name);
    row_tlp.push_back(tlp);
    row_len.push_back(len);
    row_fill.push_back(fill);
    row_edb.push_back(edb);
  endtask

  task automatic load_table();
    // start lane follows from the running byte count
    add_row("tlp_len1", 1, 1, 0, 0);
    add_row("dllp_len2_b2b", 0, 2, 0, 0);
    add_row("tlp_len3", 1, 3, 1, 0);
    add_row("dllp_len4_b2b", 0, 4, 0, 0);
    add_row("tlp_len5_edb", 1, 5, 0, 1);
    add_row("tlp_len6", 1, 6, 0, 0);
    add_row("dllp_len7", 0, 7, 2, 0);
    add_row("tlp_len8", 1, 8, 3, 0);
    add_row("tlp_len9_edb", 1, 9, 0, 1);
    add_row("dllp_len10", 0, 10, 1, 0);
    add_row("tlp_len11", 1, 11, 5, 0);
    add_row("tlp_len12", 1, 12, 0, 0);
    add_row("dllp_len12_edb", 0, 12, 1, 1);
    add_row("tlp_len4_b2b", 1, 4, 0, 0);
    add_row("tlp_len1_b2b", 1, 1, 0, 0);
    add_row("dllp_len6", 0, 6, 2, 0);
  endtask

  task automatic push_sym(logic [7:0] b, bit k);
    sym_q.push_back(b);
    symk_q.push_back(k);
  endtask

  task automatic build_stimulus();
    logic [31:0] w;
    logic [3:0]  wk;
    int          n;
    for (int r = 0; r < row_name.size(); r++) begin
      for (int f = 0; f < row_fill[r]; f++) begin
        push_sym(SYM_IDLE, 1'b0);
      end
      push_sym(row_tlp[r] ? SYM_STP : SYM_SDP, 1'b1);
      for (int b = 0; b < row_len[r]; b++) begin
        push_sym(payload_byte(r, b), 1'b0);
      end
      push_sym(row_edb[r] ? SYM_EDB : SYM_END, 1'b1);
      // payload grouped in fours with the lowest lane first
      for (int b = 0; b < row_len[r]; b += 4) begin
        n  = (row_len[r] - b < 4) ? row_len[r] - b : 4;
        w  = '0;
        wk = '0;
        for (int i = 0; i < n; i++) begin
          w[8*i +: 8] = payload_byte(r, b + i);
          wk[i]       = 1'b1;
        end
        exp_data_q.push_back(w);
        exp_keep_q.push_back(wk);
        exp_last_q.push_back(b + 4 >= row_len[r]);
        exp_user_q.push_back(row_tlp[r]);
        exp_row_q.push_back(r);
      end
    end
    // pad the tail word with idles
    while ((sym_q.size() % 4) != 0) begin
      push_sym(SYM_IDLE, 1'b0);
    end
    for (int i = 0; i < sym_q.size(); i += 4) begin
      for (int j = 0; j < 4; j++) begin
        w[8*j +: 8] = sym_q[i + j];
        wk[j]       = symk_q[i + j];
      end
      fifo_data_q.push_back(w);
      fifo_k_q.push_back(wk);
    end
  endtask

  task automatic report_mismatch(string name, string field, logic [31:0] exp_v,
                                 logic [31:0] act_v);
    $display("** Error: %s %s expected %h actual %h", name, field, exp_v, act_v);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_failure(string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  initial begin : main
    int    cycle_cnt;
    int    cycle_limit;
    int    beats_seen;
    int    exp_total;
    int    settle;
    int    r;
    bit    link_seen;
    bit    s_rd;
    bit    s_valid;
    bit    s_ready;
    string nm;

    void'($urandom(32'h779a0a8c));
    phy_link_up = 1'b0;
    data        = '0;
    data_k      = '0;
    data_valid  = 1'b0;
    tready      = 1'b1;
    cycle_cnt   = 0;
    beats_seen  = 0;
    settle      = 0;
    link_seen   = 1'b0;

    load_table();
    build_stimulus();
    exp_total   = exp_data_q.size();
    cycle_limit = 40 * fifo_data_q.size() + 200;

    do @(negedge clk); while (rst);
    @(posedge clk);
    #2;

    while ((beats_seen < exp_total) || (settle < SETTLE_CYCLES)) begin
      // outputs settled by mid cycle
      @(negedge clk);
      s_rd    = fifo_rd_en;
      s_valid = tvalid;
      s_ready = tready;
      assert (cycle_cnt < cycle_limit)
        else report_failure("timeout, expected beats did not all arrive");
      if (!phy_link_up) begin
        assert (!s_rd) else report_failure("fifo read while link is down");
      end
      if (!link_seen) begin
        assert (!s_valid) else report_failure("beat before the link ever came up");
      end
      if (beats_seen == exp_total) begin
        assert (!s_valid) else report_failure("extra beat after the last packet");
        settle++;
      end else if (s_valid && s_ready) begin
        r  = exp_row_q.pop_front();
        nm = row_name[r];
        // unused lanes of a short beat are don't care
        assert ((tdata & keep_mask(exp_keep_q[0])) == exp_data_q[0])
          else report_mismatch(nm, "tdata", exp_data_q[0],
                               tdata & keep_mask(exp_keep_q[0]));
        assert (tkeep == exp_keep_q[0])
          else report_mismatch(nm, "tkeep", exp_keep_q[0], tkeep);
        assert (tlast == exp_last_q[0])
          else report_mismatch(nm, "tlast", exp_last_q[0], tlast);
        assert (tuser == exp_user_q[0])
          else report_mismatch(nm, "tuser", exp_user_q[0], tuser);
        void'(exp_data_q.pop_front());
        void'(exp_keep_q.pop_front());
        void'(exp_last_q.pop_front());
        void'(exp_user_q.pop_front());
        beats_seen++;
      end

      @(posedge clk);
      #2;
      // head word consumed at this edge
      if (s_rd) begin
        assert (fifo_data_q.size() > 0) else report_failure("read from an empty fifo");
        void'(fifo_data_q.pop_front());
        void'(fifo_k_q.pop_front());
      end
      cycle_cnt++;
      phy_link_up = (cycle_cnt >= LINK_UP_CYCLE) &&
                    !((cycle_cnt >= DROP_FIRST) && (cycle_cnt < DROP_LAST));
      link_seen   = link_seen || phy_link_up;
      tready      = pick_ready(beats_seen);
      // fwft head word
      data_valid  = (fifo_data_q.size() > 0);
      data        = data_valid ? fifo_data_q[0] : '0;
      data_k      = data_valid ? fifo_k_q[0] : '0;
    end

    if (fifo_data_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      report_failure("fifo words left unread");
    end
  end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released just after an edge, like other stimulus
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* hw/pcie_rx_data_handler.sv */
`default_nettype none
`timescale 1ns/1ps

module pcie_rx_data_handler #(
  parameter int  DATA_WIDTH = 32,
  localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  // phy fifo side, first word fall through
  input  logic                                       phy_link_up_i,
  input  logic [8*pcie_symbol_pkg::SYMBOL_BYTES-1:0] data_i,
  input  logic [pcie_symbol_pkg::SYMBOL_BYTES-1:0]   data_k_i,
  input  logic                                       data_valid_i,
  output logic                                       phy_fifo_rd_en_o,
  // packet stream out, tuser high for tlp
  output logic [DATA_WIDTH-1:0]                      m_axis_tdata_o,
  output logic [KEEP_WIDTH-1:0]                      m_axis_tkeep_o,
  output logic                                       m_axis_tvalid_o,
  output logic                                       m_axis_tlast_o,
  output logic                                       m_axis_tuser_o,
  input  logic                                       m_axis_tready_i
);

  // framer to buffer stream
  rx_axis_if #(.DATA_WIDTH(DATA_WIDTH)) axis_int ();

  rx_framer #(.DATA_WIDTH(DATA_WIDTH)) u_rx_framer (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .phy_link_up_i   (phy_link_up_i),
    .data_i          (data_i),
    .data_k_i        (data_k_i),
    .data_valid_i    (data_valid_i),
    .phy_fifo_rd_en_o(phy_fifo_rd_en_o),
    .axis            (axis_int.source)
  );

  // output stage, breaks the ready path
  axis_skid_buffer #(.DATA_WIDTH(DATA_WIDTH)) u_axis_skid_buffer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .m_tready_i(m_axis_tready_i),
    .s         (axis_int.sink),
    .m_tdata_o (m_axis_tdata_o),
    .m_tkeep_o (m_axis_tkeep_o),
    .m_tvalid_o(m_axis_tvalid_o),
    .m_tlast_o (m_axis_tlast_o),
    .m_tuser_o (m_axis_tuser_o)
  );

endmodule

`default_nettype wire

/* hw/axis_skid_buffer.sv */
`default_nettype none
`timescale 1ns/1ps

module axis_skid_buffer #(
  parameter int  DATA_WIDTH = 32,
  localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     m_tready_i,
  rx_axis_if.sink                  s,
  output logic [DATA_WIDTH-1:0]    m_tdata_o,
  output logic [KEEP_WIDTH-1:0]    m_tkeep_o,
  output logic                     m_tvalid_o,
  output logic                     m_tlast_o,
  output rx_stream_pkg::pkt_kind_e m_tuser_o
);
  import rx_stream_pkg::*;

  // second entry, only used while the output stalls
  logic                  skid_valid_q;
  logic [DATA_WIDTH-1:0] skid_data_q;
  logic [KEEP_WIDTH-1:0] skid_keep_q;
  logic                  skid_last_q;
  pkt_kind_e             skid_user_q;

  logic load_out;
  logic load_skid;

  // ready comes straight from a flop
  assign s.tready = !skid_valid_q;

  // output register free or emptying this cycle
  assign load_out  = m_tready_i || !m_tvalid_o;
  // input accepted while output is stuck
  assign load_skid = !load_out && s.tvalid && s.tready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      m_tvalid_o   <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (load_out) begin
      // skid entry goes first to keep order
      m_tvalid_o   <= skid_valid_q || s.tvalid;
      skid_valid_q <= 1'b0;
    end else if (load_skid) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_out && skid_valid_q) begin
      m_tdata_o <= skid_data_q;
      m_tkeep_o <= skid_keep_q;
      m_tlast_o <= skid_last_q;
      m_tuser_o <= skid_user_q;
    end else if (load_out) begin
      m_tdata_o <= s.tdata;
      m_tkeep_o <= s.tkeep;
      m_tlast_o <= s.tlast;
      m_tuser_o <= s.tuser;
    end
    if (load_skid) begin
      skid_data_q <= s.tdata;
      skid_keep_q <= s.tkeep;
      skid_last_q <= s.tlast;
      skid_user_q <= s.tuser;
    end
  end

  // a stalled beat stays put until taken
  a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (m_tvalid_o && !m_tready_i) |=> (m_tvalid_o && $stable(m_tdata_o) &&
      $stable(m_tkeep_o) && $stable(m_tlast_o) && $stable(m_tuser_o)));

endmodule

`default_nettype wire

/* hw/rx_framer.sv */
`default_nettype none
`timescale 1ns/1ps

module rx_framer #(
  parameter int  DATA_WIDTH = 32,
  localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic                                       phy_link_up_i,
  input  logic [8*pcie_symbol_pkg::SYMBOL_BYTES-1:0] data_i,
  input  logic [pcie_symbol_pkg::SYMBOL_BYTES-1:0]   data_k_i,
  input  logic                                       data_valid_i,
  output logic                                       phy_fifo_rd_en_o,
  rx_axis_if.source                                  axis
);
  import pcie_symbol_pkg::*;
  import rx_stream_pkg::*;

  // one spare bit so an overfill would be visible
  localparam int CNT_W = $clog2(ACC_BYTES) + 1;

  framer_state_e  state_q, state_d;
  byte_idx_t      offset_q, offset_d;
  pkt_kind_e      kind_q, kind_d;
  sym_byte_t      acc_q [ACC_BYTES];
  sym_byte_t      acc_d [ACC_BYTES];
  logic [CNT_W-1:0] cnt_q, cnt_d;
  // bytes appended this cycle and where they land
  logic [CNT_W-1:0] n_app;
  logic [CNT_W-1:0] base;
  logic             start_found, end_found, end_here;
  byte_idx_t        start_pos, end_pos;
  pkt_kind_e        start_kind;
  logic             word_ok, act, pop, beat_fire;
  logic [8*SYMBOL_BYTES-1:0] word_sh;

  frame_symbol_scan u_scan (
    .word_i       (data_i),
    .k_i          (data_k_i),
    .from_i       (offset_q),
    .start_found_o(start_found),
    .start_pos_o  (start_pos),
    .start_kind_o (start_kind),
    .end_found_o  (end_found),
    .end_pos_o    (end_pos)
  );

  assign word_ok   = phy_link_up_i && data_valid_i;
  // end symbol sits right at the offset, nothing left to append
  assign end_here  = end_found && (end_pos == offset_q);
  assign beat_fire = axis.tvalid && axis.tready;
  // unread bytes moved down to lane 0
  assign word_sh   = data_i >> (8 * offset_q);

  // with exactly one beat held, offer it only if more payload is known
  // to follow, so the final beat can still carry tlast
  always_comb begin : beat_offer
    case (state_q)
      ST_PACKET: axis.tvalid = (cnt_q > KEEP_WIDTH) ||
                               ((cnt_q == KEEP_WIDTH) && data_valid_i && !end_here);
      ST_DRAIN:  axis.tvalid = (cnt_q != '0);
      default:   axis.tvalid = 1'b0;
    endcase
  end

  assign axis.tlast = (state_q == ST_DRAIN) && (cnt_q <= KEEP_WIDTH);
  assign axis.tuser = kind_q;

  // oldest byte on lane 0, keep bits contiguous from the bottom
  always_comb begin : beat_payload
    for (int i = 0; i < KEEP_WIDTH; i++) begin
      axis.tdata[8*i +: 8] = acc_q[i];
      axis.tkeep[i]        = (i < cnt_q);
    end
  end

  always_comb begin : next_state
    state_d  = state_q;
    offset_d = offset_q;
    kind_d   = kind_q;
    acc_d    = acc_q;
    cnt_d    = cnt_q;
    base     = cnt_q;
    n_app    = '0;
    act      = 1'b0;
    pop      = 1'b0;

    // a leaving beat shifts the accumulator down
    if (beat_fire) begin
      for (int i = 0; i < ACC_BYTES - KEEP_WIDTH; i++) begin
        acc_d[i] = acc_q[i + KEEP_WIDTH];
      end
      base  = (cnt_q > KEEP_WIDTH) ? cnt_q - CNT_W'(KEEP_WIDTH) : '0;
      cnt_d = base;
    end

    case (state_q)
      ST_HUNT: begin
        act = word_ok;
        if (act && start_found) begin
          kind_d   = start_kind;
          offset_d = byte_idx_t'(start_pos + 2'd1);
          pop      = (start_pos == byte_idx_t'(SYMBOL_BYTES - 1));
          state_d  = ST_PACKET;
        end else if (act) begin
          // nothing here, drop the rest of the word
          offset_d = '0;
          pop      = 1'b1;
        end
      end
      ST_PACKET: begin
        n_app = end_found ? CNT_W'(end_pos) - CNT_W'(offset_q)
                          : CNT_W'(SYMBOL_BYTES) - CNT_W'(offset_q);
        // room check, a zero byte append always fits
        act = word_ok && ((cnt_q < KEEP_WIDTH) || beat_fire || end_here);
        if (act) begin
          for (int k = 0; k < ACC_BYTES; k++) begin
            for (int j = 0; j < SYMBOL_BYTES; j++) begin
              if ((j < n_app) && (k == base + j)) begin
                acc_d[k] = word_sh[8*j +: 8];
              end
            end
          end
          cnt_d = base + n_app;
          if (end_found) begin
            // keep the word, a new start may follow the end
            offset_d = byte_idx_t'(end_pos + 2'd1);
            pop      = (end_pos == byte_idx_t'(SYMBOL_BYTES - 1));
            state_d  = ST_DRAIN;
          end else begin
            offset_d = '0;
            pop      = 1'b1;
          end
        end
      end
      ST_DRAIN: begin
        // fifo idle here, rescan from saved offset afterwards
        if ((cnt_q == '0) || (beat_fire && axis.tlast)) begin
          state_d = ST_HUNT;
        end
      end
      default: state_d = ST_HUNT;
    endcase
  end

  assign phy_fifo_rd_en_o = act && pop;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= ST_HUNT;
      offset_q <= '0;
      cnt_q    <= '0;
    end else begin
      state_q  <= state_d;
      offset_q <= offset_d;
      cnt_q    <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    kind_q <= kind_d;
    acc_q  <= acc_d;
  end

  a_acc_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_q <= ACC_BYTES);

  a_rd_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    phy_fifo_rd_en_o |-> (data_valid_i && phy_link_up_i));

endmodule

`default_nettype wire

/* hw/frame_symbol_scan.sv */
`default_nettype none
`timescale 1ns/1ps

module frame_symbol_scan (
  input  logic [8*pcie_symbol_pkg::SYMBOL_BYTES-1:0] word_i,
  input  logic [pcie_symbol_pkg::SYMBOL_BYTES-1:0]   k_i,
  input  pcie_symbol_pkg::byte_idx_t                 from_i,
  output logic                                       start_found_o,
  output pcie_symbol_pkg::byte_idx_t                 start_pos_o,
  output rx_stream_pkg::pkt_kind_e                   start_kind_o,
  output logic                                       end_found_o,
  output pcie_symbol_pkg::byte_idx_t                 end_pos_o
);
  import pcie_symbol_pkg::*;
  import rx_stream_pkg::*;

  always_comb begin : scan
    sym_byte_t sym;

    start_found_o = 1'b0;
    start_pos_o   = '0;
    start_kind_o  = PKT_DLLP;
    end_found_o   = 1'b0;
    end_pos_o     = '0;

    // walk high to low so the lowest hit wins
    for (int i = SYMBOL_BYTES - 1; i >= 0; i--) begin
      sym = word_i[8*i +: 8];
      // bytes below the offset were already consumed
      if (k_i[i] && (i >= from_i)) begin
        // start symbols
        if ((sym == K_STP) || (sym == K_SDP)) begin
          start_found_o = 1'b1;
          start_pos_o   = byte_idx_t'(i);
          start_kind_o  = (sym == K_STP) ? PKT_TLP : PKT_DLLP;
        end
        // edb closes a packet just like end
        if ((sym == K_END) || (sym == K_EDB)) begin
          end_found_o = 1'b1;
          end_pos_o   = byte_idx_t'(i);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/rx_axis_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface rx_axis_if #(
  parameter int DATA_WIDTH = 32
) ();
  import rx_stream_pkg::*;

  localparam int KEEP_WIDTH = DATA_WIDTH / 8;

  // beat payload
  logic [DATA_WIDTH-1:0] tdata;
  logic [KEEP_WIDTH-1:0] tkeep;
  logic                  tlast;
  // tlp or dllp
  pkt_kind_e             tuser;
  // handshake
  logic                  tvalid;
  logic                  tready;

  // framer side
  modport source(output tdata, tkeep, tlast, tuser, tvalid, input tready);
  // buffer side
  modport sink(input tdata, tkeep, tlast, tuser, tvalid, output tready);

endinterface

`default_nettype wire

/* hw/rx_stream_pkg.sv */
`default_nettype none

package rx_stream_pkg;

  // packet kind, carried on tuser
  typedef enum logic {
    PKT_DLLP = 1'b0,
    PKT_TLP  = 1'b1
  } pkt_kind_e;

  // framer states
  typedef enum logic [1:0] {
    // looking for stp or sdp
    ST_HUNT,
    // collecting payload up to end or edb
    ST_PACKET,
    // flushing leftover bytes as beats
    ST_DRAIN
  } framer_state_e;

  // accumulator depth in bytes
  localparam int ACC_BYTES = 7;

endpackage

`default_nettype wire

/* hw/pcie_symbol_pkg.sv */
`default_nettype none

package pcie_symbol_pkg;

  // one phy fifo word carries four 8b/10b symbols
  localparam int SYMBOL_BYTES = 4;

  // a single decoded symbol
  typedef logic [7:0] sym_byte_t;

  // byte position inside a symbol word
  typedef logic [1:0] byte_idx_t;

  // framing control characters
  // only valid when the matching k flag is set
  typedef enum logic [7:0] {
    // K28.2 start of dllp
    K_SDP = 8'h5C,
    // K27.7 start of tlp
    K_STP = 8'hFB,
    // K29.7 good end
    K_END = 8'hFD,
    // K30.7 nullified end
    K_EDB = 8'hFE
  } sym_k_e;

endpackage

`default_nettype wire
